// ==== Makefile ====
# Verilator build and run of the cpu testbench
VERILATOR ?= verilator
TOP ?= cpu_tb
RTL_TOP ?= cpu
FILELIST ?= cpu.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== cpu.f ====
src/rv_isa_pkg.sv
src/cpu_cfg_pkg.sv
src/inst_fetch.sv
src/inst_decode.sv
src/reg_file.sv
src/alu_exec.sv
src/cpu.sv
sim/cpu_tb.sv

// ==== sim/cpu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_tb;

	localparam int NUM_INST = 400;
	// zero words behind the program, none of them may retire
	localparam int TAIL_INST = 4;
	localparam int MEM_BYTES = (NUM_INST + TAIL_INST) * cpu_cfg_pkg::INST_BYTES;
	localparam int RESET_CYCLES = 4;
	// factor 3 leaves room for rdy_in pauses
	localparam int TIMEOUT_CYCLES = NUM_INST * cpu_cfg_pkg::INST_BYTES * 3 + 200;

	logic clk_in;
	logic rst_n;
	logic rdy_in;
	cpu_cfg_pkg::byte_t mem_din;
	cpu_cfg_pkg::addr_t mem_a;
	logic retire_we;
	rv_isa_pkg::reg_addr_t retire_rd;
	rv_isa_pkg::word_t retire_data;

	cpu_cfg_pkg::byte_t mem [0:MEM_BYTES-1];
	rv_isa_pkg::word_t model_regs [0:rv_isa_pkg::REG_COUNT-1];
	// expected retires in program order
	rv_isa_pkg::reg_addr_t exp_rd [$];
	rv_isa_pkg::word_t exp_data [$];
	logic [31:0] seed = 32'h51a3_3ac8;
	int cycles = 0;
	int retired = 0;
	logic prev_rdy = 1'b1;
	cpu_cfg_pkg::addr_t prev_mem_a = '0;
	logic all_done = 1'b0;

	cpu uut (
		.clk_in      (clk_in),
		.rst_n       (rst_n),
		.rdy_in      (rdy_in),
		.mem_din     (mem_din),
		.mem_a       (mem_a),
		.retire_we   (retire_we),
		.retire_rd   (retire_rd),
		.retire_data (retire_data)
	);

	always #50 clk_in = ~clk_in;

	function automatic logic [31:0] rand_bits(input int n);
		// LCG step, the top bits are the well mixed ones
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed >> (32 - n);
	endfunction

	// mostly x0..x7 so results are read again soon
	function automatic rv_isa_pkg::reg_addr_t pick_reg();
		if (rand_bits(3) == 0)
			return 5'(rand_bits(5));
		return 5'(rand_bits(3));
	endfunction

	// executes one instruction on the model registers, 1 when it writes a register
	function automatic bit ref_exec(input rv_isa_pkg::inst_t ins, input cpu_cfg_pkg::addr_t pc,
		output rv_isa_pkg::reg_addr_t rd, output rv_isa_pkg::word_t val);
		rv_isa_pkg::word_t a;
		rv_isa_pkg::word_t b;
		logic reg_form;
		bit writes;
		rd = ins[11:7];
		reg_form = (ins[6:0] == rv_isa_pkg::OPC_OP);
		a = model_regs[ins[19:15]];
		b = reg_form ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
		writes = 1'b1;
		val = '0;
		case (ins[6:0])
			rv_isa_pkg::OPC_LUI: val = {ins[31:12], 12'h000};
			rv_isa_pkg::OPC_AUIPC: val = pc + {ins[31:12], 12'h000};
			rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
				case (ins[14:12])
					3'd0: val = (reg_form && ins[30]) ? a - b : a + b;
					3'd1: val = a << b[4:0];
					// signed compare as unsigned with the sign bits flipped
					3'd2: val = 32'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
					3'd3: val = 32'(a < b);
					3'd4: val = a ^ b;
					3'd5: val = (a >> b[4:0]) | ((ins[30] && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : '0);
					3'd6: val = a | b;
					default: val = a & b;
				endcase
			end
			default: writes = 1'b0;
		endcase
		writes = writes && (rd != 0);
		if (writes)
			model_regs[rd] = val;
		return writes;
	endfunction

	task automatic build_program();
		rv_isa_pkg::inst_t ins;
		logic [31:0] upper;
		logic [11:0] imm;
		logic [2:0] f3;
		logic [1:0] sel;
		logic alt;
		rv_isa_pkg::reg_addr_t rd;
		rv_isa_pkg::reg_addr_t rs1;
		rv_isa_pkg::reg_addr_t prev_rd;
		rv_isa_pkg::reg_addr_t exp_r;
		rv_isa_pkg::word_t exp_v;
		prev_rd = '0;
		for (int r = 0; r < rv_isa_pkg::REG_COUNT; r++)
			model_regs[r] = '0;
		for (int i = 0; i < NUM_INST + TAIL_INST; i++) begin
			upper = rand_bits(20);
			imm = 12'(rand_bits(12));
			f3 = 3'(rand_bits(3));
			sel = 2'(rand_bits(2));
			alt = 1'(rand_bits(1));
			rd = pick_reg();
			// about half the sources chain on the previous rd
			rs1 = (rand_bits(1) != 0) ? prev_rd : pick_reg();
			case (rand_bits(3))
				0: ins = {upper[19:0], rd, rv_isa_pkg::OPC_LUI};
				1: ins = {upper[19:0], rd, rv_isa_pkg::OPC_AUIPC};
				2, 3, 4: begin
					// shamt 0 and 31 weighted up, bit 30 selects SRAI
					if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SR)
						imm = {1'b0, alt && f3 == rv_isa_pkg::F3_SR, 5'b0,
							(sel == 0) ? 5'd0 : (sel == 1) ? 5'd31 : 5'(rand_bits(5))};
					ins = {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
				end
				5, 6: begin
					alt = alt && (f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR);
					ins = {1'b0, alt, 5'b0, pick_reg(), rs1, f3, rd, rv_isa_pkg::OPC_OP};
				end
				// unsupported, a branch or an all-zero word
				default: ins = alt ? '0 : {imm, rs1, f3, rd, 7'b1100011};
			endcase
			if (i >= NUM_INST)
				ins = '0;
			prev_rd = rd;
			for (int b = 0; b < cpu_cfg_pkg::INST_BYTES; b++)
				mem[i * cpu_cfg_pkg::INST_BYTES + b] = ins[b * 8 +: 8];
			if (ref_exec(ins, cpu_cfg_pkg::addr_t'(i * cpu_cfg_pkg::INST_BYTES), exp_r, exp_v)) begin
				exp_rd.push_back(exp_r);
				exp_data.push_back(exp_v);
			end
		end
	endtask

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// reset, rdy_in and the memory byte all change 1 ns after the rising edge
	always @(posedge clk_in) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d retires checked", TIMEOUT_CYCLES, retired);
			abort_run();
		end else begin
			#1;
			if (cycles >= RESET_CYCLES) begin
				rst_n = 1'b1;
				// low for about a quarter of the cycles
				rdy_in = (rand_bits(2) != 0);
			end
			// byte for the address the core put out at this edge
			mem_din = (mem_a < MEM_BYTES) ? mem[mem_a] : 8'h00;
		end
	end

	// mid-cycle sampling sees what the next edge will act on
	always @(negedge clk_in) begin
		if (rst_n) begin
			if (!prev_rdy)
				check_value("mem_a", mem_a, prev_mem_a);
			prev_rdy = rdy_in;
			prev_mem_a = mem_a;
			if (rdy_in && retire_we) begin
				if (exp_rd.size() == 0) begin
					$display("unexpected retire of x%0d, no instruction was left to retire", retire_rd);
					abort_run();
				end else begin
					check_value("retire_rd", 32'(retire_rd), 32'(exp_rd[0]));
					check_value("retire_data", retire_data, exp_data[0]);
					exp_rd.delete(0);
					exp_data.delete(0);
					retired++;
				end
			end
			all_done = (exp_rd.size() == 0) && (mem_a >= MEM_BYTES);
		end
	end

	initial begin
		clk_in = 1'b0;
		rst_n = 1'b0;
		rdy_in = 1'b1;
		mem_din = '0;
		build_program();
		$display("%0d instructions, %0d expected retires", NUM_INST, exp_rd.size());
		while (!all_done)
			@(posedge clk_in);
		$display("%0d retires checked", retired);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/alu_exec.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu_exec (
	input  wire                           clk_in,
	input  wire                           rst_n,
	input  wire                           rdy_in,
	input  wire                           ex_valid,
	input  wire rv_isa_pkg::alu_op_t      ex_op,
	input  wire rv_isa_pkg::word_t        ex_a,
	input  wire rv_isa_pkg::word_t        ex_b,
	input  wire rv_isa_pkg::reg_addr_t    ex_rd,
	output logic                          retire_we,
	output rv_isa_pkg::reg_addr_t         retire_rd,
	output rv_isa_pkg::word_t             retire_data
);

	// shift amount is the low 5 bits of operand b
	logic [4:0] shamt;
	rv_isa_pkg::word_t result;

	assign shamt = ex_b[4:0];

	always_comb begin
		case (ex_op)
			rv_isa_pkg::ALU_ADD:    result = ex_a + ex_b;
			rv_isa_pkg::ALU_SUB:    result = ex_a - ex_b;
			rv_isa_pkg::ALU_SLL:    result = ex_a << shamt;
			rv_isa_pkg::ALU_SLT:    result = {31'b0, $signed(ex_a) < $signed(ex_b)};
			rv_isa_pkg::ALU_SLTU:   result = {31'b0, ex_a < ex_b};
			rv_isa_pkg::ALU_XOR:    result = ex_a ^ ex_b;
			rv_isa_pkg::ALU_SRL:    result = ex_a >> shamt;
			// arithmetic shift keeps the sign
			rv_isa_pkg::ALU_SRA:    result = $signed(ex_a) >>> shamt;
			rv_isa_pkg::ALU_OR:     result = ex_a | ex_b;
			rv_isa_pkg::ALU_AND:    result = ex_a & ex_b;
			rv_isa_pkg::ALU_PASS_B: result = ex_b;
			default:                result = '0;
		endcase
	end

	// retire strobe also acts as the register-file write enable
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			retire_we <= 1'b0;
		end else if (rdy_in) begin
			retire_we <= ex_valid;
		end
	end

	always_ff @(posedge clk_in) begin
		if (rdy_in && ex_valid) begin
			retire_rd   <= ex_rd;
			retire_data <= result;
		end
	end

endmodule

`default_nettype wire

// ==== src/cpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu (
	input  wire                        clk_in,
	input  wire                        rst_n,
	// pause the whole core while low
	input  wire                        rdy_in,
	input  wire cpu_cfg_pkg::byte_t    mem_din,
	output cpu_cfg_pkg::addr_t         mem_a,
	// retire port, one strobe per written register
	output logic                       retire_we,
	output rv_isa_pkg::reg_addr_t      retire_rd,
	output rv_isa_pkg::word_t          retire_data
);

	// fetch to decode
	logic inst_valid;
	rv_isa_pkg::inst_t inst;
	cpu_cfg_pkg::addr_t inst_pc;

	// decode to register file
	rv_isa_pkg::reg_addr_t rs1_addr;
	rv_isa_pkg::reg_addr_t rs2_addr;
	rv_isa_pkg::word_t rs1_data;
	rv_isa_pkg::word_t rs2_data;

	// decode to execute
	logic ex_valid;
	rv_isa_pkg::alu_op_t ex_op;
	rv_isa_pkg::word_t ex_a;
	rv_isa_pkg::word_t ex_b;
	rv_isa_pkg::reg_addr_t ex_rd;

	inst_fetch if0 (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.rdy_in     (rdy_in),
		.mem_din    (mem_din),
		.mem_a      (mem_a),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_pc    (inst_pc)
	);

	inst_decode id0 (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.rdy_in     (rdy_in),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.ex_valid   (ex_valid),
		.ex_op      (ex_op),
		.ex_a       (ex_a),
		.ex_b       (ex_b),
		.ex_rd      (ex_rd)
	);

	// write port fed by the retire registers
	reg_file regfile0 (
		.clk_in (clk_in),
		.rst_n  (rst_n),
		.rdy_in (rdy_in),
		.we     (retire_we),
		.waddr  (retire_rd),
		.wdata  (retire_data),
		.raddr1 (rs1_addr),
		.rdata1 (rs1_data),
		.raddr2 (rs2_addr),
		.rdata2 (rs2_data)
	);

	alu_exec ex0 (
		.clk_in      (clk_in),
		.rst_n       (rst_n),
		.rdy_in      (rdy_in),
		.ex_valid    (ex_valid),
		.ex_op       (ex_op),
		.ex_a        (ex_a),
		.ex_b        (ex_b),
		.ex_rd       (ex_rd),
		.retire_we   (retire_we),
		.retire_rd   (retire_rd),
		.retire_data (retire_data)
	);

endmodule

`default_nettype wire

// ==== src/cpu_cfg_pkg.sv ====
`default_nettype none

package cpu_cfg_pkg;

	// memory bus
	typedef logic [31:0] addr_t;
	typedef logic [7:0] byte_t;

	// first fetch address out of reset
	localparam addr_t RESET_PC = 32'h0000_0000;

	// bytes per instruction on the 8-bit bus
	localparam int unsigned INST_BYTES = 4;
	localparam int unsigned BYTE_IDX_W = $clog2(INST_BYTES);

	typedef logic [BYTE_IDX_W-1:0] byte_idx_t;

	// index of the byte whose capture moves fetch into its last step
	localparam byte_idx_t LAST_FILL_IDX = byte_idx_t'(INST_BYTES - 2);

	// fetch sequencer
	typedef enum logic [1:0] {
		// first address after reset is on the bus
		FETCH_ISSUE,
		// capturing the lower bytes
		FETCH_FILL,
		// capturing the top byte, word complete
		FETCH_LAST
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== src/inst_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module inst_decode (
	input  wire                        clk_in,
	input  wire                        rst_n,
	input  wire                        rdy_in,
	input  wire                        inst_valid,
	input  wire rv_isa_pkg::inst_t     inst,
	input  wire cpu_cfg_pkg::addr_t    inst_pc,
	output rv_isa_pkg::reg_addr_t      rs1_addr,
	output rv_isa_pkg::reg_addr_t      rs2_addr,
	input  wire rv_isa_pkg::word_t     rs1_data,
	input  wire rv_isa_pkg::word_t     rs2_data,
	output logic                       ex_valid,
	output rv_isa_pkg::alu_op_t        ex_op,
	output rv_isa_pkg::word_t          ex_a,
	output rv_isa_pkg::word_t          ex_b,
	output rv_isa_pkg::reg_addr_t      ex_rd
);

	rv_isa_pkg::opcode_t opcode;
	rv_isa_pkg::reg_addr_t rd;
	logic [2:0] funct3;
	// bit 30, the only funct7 bit that matters for RV32I
	logic funct7_alt;
	rv_isa_pkg::word_t imm_i;
	rv_isa_pkg::word_t imm_u;
	logic supported;
	rv_isa_pkg::alu_op_t op;
	rv_isa_pkg::word_t opnd_a;
	rv_isa_pkg::word_t opnd_b;

	// instruction fields
	assign opcode     = inst[6:0];
	assign rd         = inst[11:7];
	assign funct3     = inst[14:12];
	assign funct7_alt = inst[30];
	assign rs1_addr   = inst[19:15];
	assign rs2_addr   = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};

	// funct3 to alu op, SUB only exists in the register form
	function automatic rv_isa_pkg::alu_op_t alu_op_of(
		input logic [2:0] f3,
		input logic       alt,
		input logic       reg_form
	);
		case (f3)
			rv_isa_pkg::F3_ADD:  return (alt && reg_form) ? rv_isa_pkg::ALU_SUB
				: rv_isa_pkg::ALU_ADD;
			rv_isa_pkg::F3_SLL:  return rv_isa_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT:  return rv_isa_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU: return rv_isa_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:  return rv_isa_pkg::ALU_XOR;
			rv_isa_pkg::F3_SR:   return alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
			rv_isa_pkg::F3_OR:   return rv_isa_pkg::ALU_OR;
			default:             return rv_isa_pkg::ALU_AND;
		endcase
	endfunction

	// operand and operation select
	always_comb begin
		supported = 1'b0;
		op        = rv_isa_pkg::ALU_ADD;
		opnd_a    = rs1_data;
		opnd_b    = imm_i;
		case (opcode)
			rv_isa_pkg::OPC_LUI: begin
				supported = 1'b1;
				op        = rv_isa_pkg::ALU_PASS_B;
				opnd_a    = '0;
				opnd_b    = imm_u;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				supported = 1'b1;
				opnd_a    = inst_pc;
				opnd_b    = imm_u;
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				supported = 1'b1;
				op        = alu_op_of(funct3, funct7_alt, 1'b0);
			end
			rv_isa_pkg::OPC_OP: begin
				supported = 1'b1;
				op        = alu_op_of(funct3, funct7_alt, 1'b1);
				opnd_b    = rs2_data;
			end
			default: begin
				// anything else is a nop
				supported = 1'b0;
			end
		endcase
	end

	// writes to x0 are dropped here and never reach retire
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else if (rdy_in) begin
			ex_valid <= inst_valid && supported && (rd != '0);
		end
	end

	always_ff @(posedge clk_in) begin
		if (rdy_in && inst_valid) begin
			ex_op <= op;
			ex_a  <= opnd_a;
			ex_b  <= opnd_b;
			ex_rd <= rd;
		end
	end

endmodule

`default_nettype wire

// ==== src/inst_fetch.sv ====
`default_nettype none
`timescale 1ns/1ps

module inst_fetch (
	input  wire                        clk_in,
	input  wire                        rst_n,
	input  wire                        rdy_in,
	input  wire cpu_cfg_pkg::byte_t    mem_din,
	output cpu_cfg_pkg::addr_t         mem_a,
	output logic                       inst_valid,
	output rv_isa_pkg::inst_t          inst,
	output cpu_cfg_pkg::addr_t         inst_pc
);

	cpu_cfg_pkg::fetch_state_t state;
	cpu_cfg_pkg::byte_idx_t byte_cnt;
	// address of the first byte of the instruction in flight
	cpu_cfg_pkg::addr_t pc;
	// lower bytes collected so far, little-endian
	logic [(cpu_cfg_pkg::INST_BYTES-1)*8-1:0] byte_buf;

	// sequencer, pc and bus address
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			state      <= cpu_cfg_pkg::FETCH_ISSUE;
			byte_cnt   <= '0;
			pc         <= cpu_cfg_pkg::RESET_PC;
			mem_a      <= cpu_cfg_pkg::RESET_PC;
			inst_valid <= 1'b0;
		end else if (rdy_in) begin
			inst_valid <= 1'b0;
			case (state)
				cpu_cfg_pkg::FETCH_ISSUE: begin
					// mem_a already holds the reset pc
					byte_cnt <= '0;
					state    <= cpu_cfg_pkg::FETCH_FILL;
				end
				cpu_cfg_pkg::FETCH_FILL: begin
					byte_cnt <= byte_cnt + 1'b1;
					mem_a    <= mem_a + 32'd1;
					if (byte_cnt == cpu_cfg_pkg::LAST_FILL_IDX) begin
						state <= cpu_cfg_pkg::FETCH_LAST;
					end
				end
				cpu_cfg_pkg::FETCH_LAST: begin
					// word done, next instruction starts on the same edge
					inst_valid <= 1'b1;
					byte_cnt   <= '0;
					pc         <= pc + cpu_cfg_pkg::INST_BYTES;
					mem_a      <= pc + cpu_cfg_pkg::INST_BYTES;
					state      <= cpu_cfg_pkg::FETCH_FILL;
				end
				default: begin
					state <= cpu_cfg_pkg::FETCH_ISSUE;
				end
			endcase
		end
	end

	// byte assembly
	always_ff @(posedge clk_in) begin
		if (rdy_in) begin
			if (state == cpu_cfg_pkg::FETCH_FILL) begin
				byte_buf[{byte_cnt, 3'b000} +: 8] <= mem_din;
			end
			if (state == cpu_cfg_pkg::FETCH_LAST) begin
				// top byte comes straight off the bus
				inst    <= {mem_din, byte_buf};
				inst_pc <= pc;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file (
	input  wire                           clk_in,
	input  wire                           rst_n,
	input  wire                           rdy_in,
	input  wire                           we,
	input  wire rv_isa_pkg::reg_addr_t    waddr,
	input  wire rv_isa_pkg::word_t        wdata,
	input  wire rv_isa_pkg::reg_addr_t    raddr1,
	output rv_isa_pkg::word_t             rdata1,
	input  wire rv_isa_pkg::reg_addr_t    raddr2,
	output rv_isa_pkg::word_t             rdata2
);

	// entry 0 is cleared at reset and never written, so x0 reads zero
	rv_isa_pkg::word_t regs [0:rv_isa_pkg::REG_COUNT-1];

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rv_isa_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (rdy_in && we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// asynchronous read ports
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// ==== src/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	// architectural widths
	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [6:0] opcode_t;

	// number of integer registers, x0 included
	localparam int unsigned REG_COUNT = 32;

	// major opcodes the core executes
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;

	// funct3 values shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	// SRL and SRA, told apart by instruction bit 30
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// operations of the execute stage
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		// operand b straight through, for LUI
		ALU_PASS_B
	} alu_op_t;

endpackage

`default_nettype wire
